// File: uart_consts.svh
// Frame size, queue depth and derived width macros for the echo UART
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Serial frame format
`define UART_DATA_BITS 8
`define UART_STOP_BITS 2

// Bit counter wide enough for data and stop phases
`define UART_CNT_BITS $clog2(`UART_DATA_BITS + 1)

// Byte queue geometry, 16 entries
`define QUEUE_ADDR_BITS 4
`define QUEUE_DEPTH (1 << `QUEUE_ADDR_BITS)

// Occupancy needs one bit more than the address to reach a full queue
`define QUEUE_CNT_BITS (`QUEUE_ADDR_BITS + 1)

`endif

// File: uartPkg.sv
// Serial line types: receiver states, transmitter states, receive error vector
`default_nettype none

package uartPkg;

	// Receiver FSM, one state per frame phase
	typedef enum logic [2:0]
	{
		Ready,
		StartBit,
		RxWait,
		Parity,
		StopBit,
		RxDone
	} rxStateT;

	// Transmitter FSM, fetch from queue then shift out
	typedef enum logic [2:0]
	{
		TxIdle,
		TxFetch,
		TxStart,
		TxData,
		TxParity,
		TxStop
	} txStateT;

	// Error vector: bit 2 framing, bit 1 parity, bit 0 break
	typedef enum logic [2:0]
	{
		ErrNone          = 3'b000,
		ErrBreak         = 3'b001,
		ErrParity        = 3'b010,
		ErrParityBreak   = 3'b011,
		ErrFraming       = 3'b100,
		ErrFramingBreak  = 3'b101,
		ErrFramingParity = 3'b110,
		ErrAll           = 3'b111
	} rxErrorT;

endpackage

`default_nettype wire

// File: busPkg.sv
// Shared queue access types: access opcode and grant owner
`default_nettype none

package busPkg;

	// Memory access performed in one cycle
	typedef enum logic [1:0]
	{
		OpIdle  = 2'b00,
		OpWrite = 2'b01,
		OpRead  = 2'b10
	} accessOpT;

	// Owner of the single memory port in one cycle
	typedef enum logic [1:0]
	{
		GrantNone   = 2'b00,
		GrantWriter = 2'b01,
		GrantReader = 2'b10
	} grantT;

endpackage

`default_nettype wire

// File: uartRx.sv
// uartRx module: one-bit-per-clock frame receiver with break, parity and framing checks
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uartRx
(
	input  logic                       Clk,
	input  logic                       Rst,
	input  logic                       RxIn,
	output logic                       Rts,
	output logic                       DataRdy,
	output logic [`UART_DATA_BITS-1:0] RxData,
	output uartPkg::rxErrorT           RxError
);

	localparam int CntW = `UART_CNT_BITS;
	localparam logic [CntW-1:0] LastData = CntW'(`UART_DATA_BITS - 1);
	localparam logic [CntW-1:0] LastStop = CntW'(`UART_STOP_BITS - 1);

	uartPkg::rxStateT state;
	uartPkg::rxStateT nextState;
	logic [CntW-1:0] bitCnt;
	logic [`UART_DATA_BITS-1:0] dataReg;
	logic parityReg;
	logic [`UART_STOP_BITS-1:0] stopReg;
	logic breakErr;
	logic parityErr;
	logic framingErr;

	// Next state
	always_comb
	begin
		nextState = state;
		case (state)
			uartPkg::Ready:
				if (!RxIn)
					nextState = uartPkg::StartBit;
			uartPkg::StartBit:
				nextState = uartPkg::RxWait;
			uartPkg::RxWait:
				if (bitCnt == LastData)
					nextState = uartPkg::Parity;
			uartPkg::Parity:
				nextState = uartPkg::StopBit;
			uartPkg::StopBit:
				if (bitCnt == LastStop)
					nextState = uartPkg::RxDone;
			default:
				nextState = uartPkg::Ready;
		endcase
	end

	// State and bit counter
	// The counter runs on from StartBit into RxWait so StartBit holds the first data bit
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state  <= uartPkg::Ready;
			bitCnt <= '0;
		end
		else
		begin
			state <= nextState;
			case (state)
				uartPkg::StartBit,
				uartPkg::RxWait,
				uartPkg::StopBit:
					bitCnt <= bitCnt + 1'b1;
				default:
					bitCnt <= '0;
			endcase
		end
	end

	// Shift in data MSB first, then capture parity and stop bits
	always_ff @(posedge Clk)
	begin
		if (state == uartPkg::StartBit || state == uartPkg::RxWait)
			dataReg <= {dataReg[`UART_DATA_BITS-2:0], RxIn};
		else if (state == uartPkg::Parity)
			parityReg <= RxIn;
		else if (state == uartPkg::StopBit)
			stopReg <= {stopReg[`UART_STOP_BITS-2:0], RxIn};
	end

	assign framingErr = (stopReg != '1);
	// Even parity over the data bits
	assign parityErr  = ((^dataReg) != parityReg);
	assign breakErr   = (dataReg == '0) && framingErr;

	// Outputs only carry a result in RxDone
	always_comb
	begin
		Rts     = 1'b0;
		DataRdy = 1'b0;
		RxData  = '0;
		RxError = uartPkg::ErrNone;
		if (state == uartPkg::Ready)
			Rts = 1'b1;
		else if (state == uartPkg::RxDone)
		begin
			Rts     = 1'b1;
			RxError = uartPkg::rxErrorT'({framingErr, parityErr, breakErr});
			if (!framingErr && !parityErr && !breakErr)
			begin
				DataRdy = 1'b1;
				RxData  = dataReg;
			end
		end
	end

	rxOutKnownA: assert property (@(posedge Clk) disable iff (Rst)
		!$isunknown({Rts, DataRdy, RxData, RxError}));

	// Receiver is back in Ready and requesting data after each frame
	rxRtsAfterDoneA: assert property (@(posedge Clk) disable iff (Rst)
		(state == uartPkg::RxDone) |=> Rts);

	rxRdyXorErrA: assert property (@(posedge Clk) disable iff (Rst)
		!(DataRdy && (RxError != uartPkg::ErrNone)));

endmodule

`default_nettype wire

// File: rxWriter.sv
// rxWriter module: one-byte holding register between receiver and queue, with overrun report
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module rxWriter
(
	input  logic                       Clk,
	input  logic                       Rst,
	input  logic                       DataRdy,
	input  logic [`UART_DATA_BITS-1:0] RxData,
	output logic                       WrReq,
	output logic [`UART_DATA_BITS-1:0] WrData,
	input  logic                       WrAck,
	output logic                       Overrun
);

	logic pending;
	logic accept;
	logic [`UART_DATA_BITS-1:0] holdReg;

	// A new byte is taken when the register is free or empties this cycle
	assign accept = DataRdy && (!pending || WrAck);

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			pending <= 1'b0;
			Overrun <= 1'b0;
		end
		else
		begin
			Overrun <= DataRdy && pending && !WrAck;
			if (accept)
				pending <= 1'b1;
			else if (WrAck)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (accept)
			holdReg <= RxData;
	end

	assign WrReq  = pending;
	assign WrData = holdReg;

	// Held byte must not change while the queue keeps it waiting
	wrDataStableA: assert property (@(posedge Clk) disable iff (Rst)
		(WrReq && !WrAck) |=> $stable(WrData));

endmodule

`default_nettype wire

// File: queueArbiter.sv
// Single-port byte queue with fixed-priority write and read arbitration
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module queueArbiter
(
	input  logic                       Clk,
	input  logic                       Rst,
	input  logic                       WrReq,
	input  logic [`UART_DATA_BITS-1:0] WrData,
	output logic                       WrAck,
	input  logic                       RdReq,
	output logic                       RdAck,
	output logic [`UART_DATA_BITS-1:0] RdData,
	output logic                       RdValid
);

	localparam int CntW = `QUEUE_CNT_BITS;
	localparam logic [CntW-1:0] Depth = CntW'(`QUEUE_DEPTH);

	logic [`UART_DATA_BITS-1:0] mem [`QUEUE_DEPTH];
	logic [`QUEUE_ADDR_BITS-1:0] wrPtr;
	logic [`QUEUE_ADDR_BITS-1:0] rdPtr;
	logic [`QUEUE_ADDR_BITS-1:0] memAddr;
	logic [CntW-1:0] count;
	logic full;
	logic empty;
	busPkg::grantT grant;
	busPkg::accessOpT accessOp;

	assign full  = (count == Depth);
	assign empty = (count == '0);

	// Writer wins; a refused write leaves the port free for a read
	always_comb
	begin
		if (WrReq && !full)
			grant = busPkg::GrantWriter;
		else if (RdReq && !empty)
			grant = busPkg::GrantReader;
		else
			grant = busPkg::GrantNone;
	end

	// Port address and access type follow the owner
	always_comb
	begin
		case (grant)
			busPkg::GrantWriter:
			begin
				accessOp = busPkg::OpWrite;
				memAddr  = wrPtr;
			end
			busPkg::GrantReader:
			begin
				accessOp = busPkg::OpRead;
				memAddr  = rdPtr;
			end
			default:
			begin
				accessOp = busPkg::OpIdle;
				memAddr  = rdPtr;
			end
		endcase
	end

	assign WrAck = (grant == busPkg::GrantWriter);
	assign RdAck = (grant == busPkg::GrantReader);

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			RdValid <= 1'b0;
		end
		else
		begin
			RdValid <= (accessOp == busPkg::OpRead);
			if (accessOp == busPkg::OpWrite)
			begin
				wrPtr <= wrPtr + 1'b1;
				count <= count + 1'b1;
			end
			else if (accessOp == busPkg::OpRead)
			begin
				rdPtr <= rdPtr + 1'b1;
				count <= count - 1'b1;
			end
		end
	end

	// The single memory port
	always_ff @(posedge Clk)
	begin
		if (accessOp == busPkg::OpWrite)
			mem[memAddr] <= WrData;
		else if (accessOp == busPkg::OpRead)
			RdData <= mem[memAddr];
	end

	// Only one pointer moves per cycle on the single port
	oneAccessA: assert property (@(posedge Clk) disable iff (Rst)
		$stable(wrPtr) || $stable(rdPtr));

	countBoundA: assert property (@(posedge Clk) disable iff (Rst)
		count <= Depth);

endmodule

`default_nettype wire

// File: uartTx.sv
// uartTx module: queue reader and frame serializer with Cts flow control
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uartTx
(
	input  logic                       Clk,
	input  logic                       Rst,
	input  logic                       Cts,
	output logic                       RdReq,
	input  logic                       RdAck,
	input  logic [`UART_DATA_BITS-1:0] RdData,
	input  logic                       RdValid,
	output logic                       Tx
);

	localparam int CntW = `UART_CNT_BITS;
	localparam logic [CntW-1:0] LastData = CntW'(`UART_DATA_BITS - 1);
	localparam logic [CntW-1:0] LastStop = CntW'(`UART_STOP_BITS - 1);

	uartPkg::txStateT state;
	uartPkg::txStateT nextState;
	logic [CntW-1:0] bitCnt;
	logic [`UART_DATA_BITS-1:0] shiftReg;
	logic parityBit;

	assign RdReq = (state == uartPkg::TxFetch);

	// Cts only matters in TxIdle, a started frame always finishes
	always_comb
	begin
		nextState = state;
		case (state)
			uartPkg::TxIdle:
				if (Cts)
					nextState = uartPkg::TxFetch;
			uartPkg::TxFetch:
				nextState = RdAck ? uartPkg::TxStart : uartPkg::TxIdle;
			uartPkg::TxStart:
				nextState = RdValid ? uartPkg::TxData : uartPkg::TxIdle;
			uartPkg::TxData:
				if (bitCnt == LastData)
					nextState = uartPkg::TxParity;
			uartPkg::TxParity:
				nextState = uartPkg::TxStop;
			uartPkg::TxStop:
				if (bitCnt == LastStop)
					nextState = uartPkg::TxIdle;
			default:
				nextState = uartPkg::TxIdle;
		endcase
	end

	// Tx is registered, so each state sets the bit seen on the next cycle
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state  <= uartPkg::TxIdle;
			bitCnt <= '0;
			Tx     <= 1'b1;
		end
		else
		begin
			state <= nextState;
			case (state)
				uartPkg::TxStart:
				begin
					// Start bit
					Tx     <= !RdValid;
					bitCnt <= '0;
				end
				uartPkg::TxData:
				begin
					Tx     <= shiftReg[`UART_DATA_BITS-1];
					bitCnt <= bitCnt + 1'b1;
				end
				uartPkg::TxParity:
				begin
					Tx     <= parityBit;
					bitCnt <= '0;
				end
				uartPkg::TxStop:
				begin
					Tx     <= 1'b1;
					bitCnt <= bitCnt + 1'b1;
				end
				default:
				begin
					Tx     <= 1'b1;
					bitCnt <= '0;
				end
			endcase
		end
	end

	// Load byte from the queue, then shift MSB first
	always_ff @(posedge Clk)
	begin
		if (state == uartPkg::TxStart && RdValid)
		begin
			shiftReg  <= RdData;
			parityBit <= ^RdData;
		end
		else if (state == uartPkg::TxData)
			shiftReg <= {shiftReg[`UART_DATA_BITS-2:0], 1'b0};
	end

	// Line is idle whenever the FSM rests, including the last stop bit
	txIdleHighA: assert property (@(posedge Clk) disable iff (Rst)
		(state == uartPkg::TxIdle) |-> Tx);

endmodule

`default_nettype wire

// File: uartEcho.sv
// uartEcho module: top level joining receiver, holding writer, queue arbiter and transmitter
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uartEcho
(
	input  logic             Clk,
	input  logic             Rst,
	input  logic             RxIn,
	input  logic             Cts,
	output logic             Tx,
	output logic             Rts,
	output uartPkg::rxErrorT RxError,
	output logic             Overrun
);

	// Receiver to writer
	logic dataRdy;
	logic [`UART_DATA_BITS-1:0] rxData;

	// Writer to queue
	logic wrReq;
	logic wrAck;
	logic [`UART_DATA_BITS-1:0] wrData;

	// Queue to transmitter
	logic rdReq;
	logic rdAck;
	logic rdValid;
	logic [`UART_DATA_BITS-1:0] rdData;

	uartRx rx_i
	(
		.Clk     (Clk),
		.Rst     (Rst),
		.RxIn    (RxIn),
		.Rts     (Rts),
		.DataRdy (dataRdy),
		.RxData  (rxData),
		.RxError (RxError)
	);

	rxWriter writer_i
	(
		.Clk     (Clk),
		.Rst     (Rst),
		.DataRdy (dataRdy),
		.RxData  (rxData),
		.WrReq   (wrReq),
		.WrData  (wrData),
		.WrAck   (wrAck),
		.Overrun (Overrun)
	);

	queueArbiter queue_i
	(
		.Clk     (Clk),
		.Rst     (Rst),
		.WrReq   (wrReq),
		.WrData  (wrData),
		.WrAck   (wrAck),
		.RdReq   (rdReq),
		.RdAck   (rdAck),
		.RdData  (rdData),
		.RdValid (rdValid)
	);

	uartTx tx_i
	(
		.Clk     (Clk),
		.Rst     (Rst),
		.Cts     (Cts),
		.RdReq   (rdReq),
		.RdAck   (rdAck),
		.RdData  (rdData),
		.RdValid (rdValid),
		.Tx      (Tx)
	);

endmodule

`default_nettype wire

// File: tb_uartEcho.sv
// Data-driven echo UART testbench with frame driver, Tx monitor and compare tasks
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module tb_uartEcho;

	localparam int ResetCycles  = 16;
	localparam int SettleCycles = 40;
	localparam int FrameBits    = 1 + `UART_DATA_BITS + 1 + `UART_STOP_BITS;

	logic Clk;
	logic Rst;
	logic RxIn;
	logic Cts;
	logic Tx;
	logic Rts;
	uartPkg::rxErrorT RxError;
	logic Overrun;

	// Scoreboard
	logic [`UART_DATA_BITS-1:0] expQ [$];
	logic [`UART_DATA_BITS-1:0] rxQ [$];
	int errCount;
	int checksDone;
	int testNum;
	int badTests;
	int ovrCount;
	int ovrExpected;
	logic runAborted;

	// Tx frame decoder
	int monPhase;
	logic [`UART_DATA_BITS-1:0] monByte;
	logic monParity;
	logic [`UART_STOP_BITS-1:0] monStops;

	uartEcho dut_i
	(
		.Clk     (Clk),
		.Rst     (Rst),
		.RxIn    (RxIn),
		.Cts     (Cts),
		.Tx      (Tx),
		.Rts     (Rts),
		.RxError (RxError),
		.Overrun (Overrun)
	);

	always #5 Clk = ~Clk;

	task automatic checkError(input string what, input uartPkg::rxErrorT got,
		input uartPkg::rxErrorT exp);
		checksDone++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s error vector expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic checkByte(input string what, input logic [`UART_DATA_BITS-1:0] got,
		input logic [`UART_DATA_BITS-1:0] exp);
		checksDone++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s expected 0x%h got 0x%h", $time, what, exp, got);
		end
	endtask

	task automatic checkOverrun(input string what, input logic got, input logic exp);
		checksDone++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic checkLevel(input string what, input logic got, input logic exp);
		checksDone++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic checkCount(input string what, input int got, input int exp);
		checksDone++;
		if (got != exp)
		begin
			errCount++;
			$display("ERR %0t: %s expected %0d got %0d", $time, what, exp, got);
		end
	endtask

	task automatic reportTest(input string label, input int errBefore);
		testNum++;
		if (errCount != errBefore)
			badTests++;
		$display("%0t test %0d %s: %s", $time, testNum, label,
			(errCount == errBefore) ? "ok" : "mismatch");
	endtask

	// One serial bit that the DUT samples on the next rising edge
	task automatic driveBit(input logic b);
		RxIn = b;
		@(posedge Clk);
		#1;
	endtask

	task automatic sendFrame(input logic [`UART_DATA_BITS-1:0] data, input logic parFlip,
		input logic [`UART_STOP_BITS-1:0] stops);
		int i;
		driveBit(1'b0);
		for (i = `UART_DATA_BITS - 1; i >= 0; i--)
			driveBit(data[i]);
		// Even parity with optional inversion
		driveBit((^data) ^ parFlip);
		for (i = `UART_STOP_BITS - 1; i >= 0; i--)
			driveBit(stops[i]);
	endtask

	task automatic runFrame(input logic [`UART_DATA_BITS-1:0] data, input logic parFlip,
		input logic [`UART_STOP_BITS-1:0] stops, input uartPkg::rxErrorT expErr,
		input logic expOvr);
		int ovrBefore;
		uartPkg::rxErrorT gotErr;
		ovrBefore = ovrCount;
		sendFrame(data, parFlip, stops);
		// Receiver sits in RxDone for this one cycle
		gotErr = RxError;
		driveBit(1'b1);
		driveBit(1'b1);
		checkError($sformatf("frame 0x%h", data), gotErr, expErr);
		checkOverrun($sformatf("frame 0x%h overrun", data), ovrCount != ovrBefore, expOvr);
		ovrExpected += expOvr;
		if (expErr == uartPkg::ErrNone && !expOvr)
			expQ.push_back(data);
	endtask

	task automatic waitEcho(input int limit);
		int cycles;
		cycles = 0;
		while (rxQ.size() < expQ.size() && cycles < limit)
		begin
			@(posedge Clk);
			#1;
			cycles++;
		end
		if (rxQ.size() < expQ.size())
		begin
			$display("Timeout: only %0d of %0d expected echo bytes seen after %0d cycles",
				rxQ.size(), expQ.size(), limit);
			runAborted = 1'b1;
		end
		else
		begin
			// Quiet window so that a stray echo shows up in the count
			for (cycles = 0; cycles < SettleCycles; cycles++)
			begin
				@(posedge Clk);
				#1;
			end
			checkCount("echoed bytes", rxQ.size(), expQ.size());
			while (rxQ.size() > 0 && expQ.size() > 0)
				checkByte("echo byte", rxQ.pop_front(), expQ.pop_front());
			rxQ.delete();
			expQ.delete();
		end
	endtask

	task automatic runStep(input string line);
		int n;
		int kindCh;
		int count;
		int i;
		int errBefore;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
		logic [31:0] rndWord;
		errBefore = errCount;
		n = $sscanf(line, "%c %d", kindCh, count);
		case (kindCh)
			"C":
			begin
				checkCount("bytes echoed outside a wait step", rxQ.size(), 0);
				Cts = count[0];
				reportTest($sformatf("Cts level %0d", count[0]), errBefore);
			end
			"F":
			begin
				n = $sscanf(line, "%c %h %b %b %b %b", kindCh, f1, f2, f3, f4, f5);
				runFrame(f1[`UART_DATA_BITS-1:0], f2[0], f3[`UART_STOP_BITS-1:0],
					uartPkg::rxErrorT'(f4[2:0]), f5[0]);
				reportTest($sformatf("frame 0x%h flip %b stops %b", f1[`UART_DATA_BITS-1:0],
					f2[0], f3[`UART_STOP_BITS-1:0]), errBefore);
			end
			"R":
			begin
				for (i = 0; i < count; i++)
				begin
					rndWord = $urandom;
					runFrame(rndWord[`UART_DATA_BITS-1:0], 1'b0, '1, uartPkg::ErrNone, 1'b0);
				end
				reportTest($sformatf("%0d random clean frames", count), errBefore);
			end
			"W":
			begin
				waitEcho(count);
				reportTest("echo wait", errBefore);
			end
			default:
			begin
				$display("Test file line not understood: %s", line);
				runAborted = 1'b1;
			end
		endcase
	endtask

	// Decode frames on Tx once per cycle
	always @(posedge Clk)
	begin
		if (Rst)
			monPhase = 0;
		else if (monPhase == 0)
		begin
			if (Tx === 1'b0)
				monPhase = 1;
		end
		else if (monPhase <= `UART_DATA_BITS)
		begin
			monByte  = {monByte[`UART_DATA_BITS-2:0], Tx};
			monPhase = monPhase + 1;
		end
		else if (monPhase == `UART_DATA_BITS + 1)
		begin
			monParity = Tx;
			monPhase  = monPhase + 1;
		end
		else
		begin
			monStops = {monStops[`UART_STOP_BITS-2:0], Tx};
			if (monPhase == FrameBits - 1)
			begin
				checkLevel("echo parity", monParity, ^monByte);
				checkLevel("echo stop bits", &monStops, 1'b1);
				rxQ.push_back(monByte);
				monPhase = 0;
			end
			else
				monPhase = monPhase + 1;
		end
	end

	always @(posedge Clk)
	begin
		if (!Rst && Overrun === 1'b1)
			ovrCount++;
	end

	initial
	begin : mainFlow
		int fd;
		int n;
		int i;
		int errBefore;
		int unsigned seedWord;
		string line;

		seedWord = $urandom(99137);
		Clk = 1'b0;
		Rst = 1'b1;
		RxIn = 1'b1;
		Cts = 1'b0;
		errCount = 0;
		checksDone = 0;
		testNum = 0;
		badTests = 0;
		ovrCount = 0;
		ovrExpected = 0;
		runAborted = 1'b0;

		for (i = 0; i < ResetCycles; i++)
			@(posedge Clk);
		#1;
		Rst = 1'b0;

		errBefore = errCount;
		checkLevel("Tx after reset", Tx, 1'b1);
		checkLevel("Rts after reset", Rts, 1'b1);
		checkError("RxError after reset", RxError, uartPkg::ErrNone);
		checkOverrun("Overrun after reset", Overrun, 1'b0);
		reportTest("reset state", errBefore);

		fd = $fopen("uartEcho_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open uartEcho_tests.txt, no vectors were run");
			runAborted = 1'b1;
		end
		while (fd != 0 && !runAborted && !$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#")
				runStep(line);
		end
		if (fd != 0)
			$fclose(fd);

		if (!runAborted)
		begin
			errBefore = errCount;
			checkCount("overrun pulses in run", ovrCount, ovrExpected);
			reportTest("end of run totals", errBefore);
		end

		$display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
			testNum, badTests, checksDone, errCount);
		if (errCount == 0 && !runAborted)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: uartEcho.f
+incdir+.
uartPkg.sv
busPkg.sv
uartRx.sv
rxWriter.sv
queueArbiter.sv
uartTx.sv
uartEcho.sv
tb_uartEcho.sv

// File: uartEcho_tests.txt
# F data(hex) parityFlip stopBits(bin, first stop leftmost) expRxError(bin framing parity break) expOverrun
# C ctsLevel, R count of random clean frames, W echo timeout in cycles (all decimal)
C 1
# Clean frames echoed in order
F A5 0 11 000 0
F 3C 0 11 000 0
F 00 0 11 000 0
F FF 0 11 000 0
F 81 0 11 000 0
W 300
# Inverted parity bit
F 5A 1 11 010 0
F 01 1 11 010 0
W 200
# Framing errors with nonzero data
F 7E 0 10 100 0
F 42 0 01 100 0
F C3 0 00 100 0
W 200
# Break frames, parity follows the bit sent
F 00 0 00 101 0
F 00 1 00 111 0
F 00 0 10 101 0
W 200
R 6
W 400
# Back-pressure: 16 queued, one held, the 18th dropped
C 0
R 17
F 99 0 11 000 1
C 1
W 1000
F 6D 0 11 000 0
W 200
